// ==== build.f ====
source/igr_shim_pkg.sv
source/igr_shim_decode.sv
source/igr_shim_seg.sv
source/igr_shim_result.sv
source/igr_shim_top.sv
test/igr_shim_asserts.sv
test/igr_shim_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the ingress shim testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module igr_shim_tb -f build.f --Mdir obj_dir

# a failing run still reaches the search below
out=$(./obj_dir/Vigr_shim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^TB PASSED$'; then
  echo "simulation result: pass"
  exit 0
fi
echo "simulation result: fail"
exit 1

// ==== source/igr_shim_decode.sv ====
//--------------------------------------------------------------------------
// decode stage of the ingress shim
// tracks segment fill and packet state, and works out for each segment
// slot which input lane feeds it, plus the write, wrap and close strobes
// all strobes are combinational from the current beat and the fill counter
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module igr_shim_decode (
  input  logic                  cclk,
  input  logic                  rst,
  input  logic                  i_rx_v,
  input  igr_shim_pkg::nwords_t i_rx_nwords,
  input  logic                  i_rx_sop,
  input  logic                  i_rx_eop,
  output igr_shim_pkg::lane_sel_t [igr_shim_pkg::SEG_WORDS-1:0] o_slot_sel,
  output igr_shim_pkg::slot_mask_t o_slot_we,
  output igr_shim_pkg::slot_mask_t o_wrap_we,
  output logic                  o_sop_cap,
  output logic                  o_seg_close,
  output logic                  o_close_eop,
  output igr_shim_pkg::fill_t   o_close_pos,
  output logic                  o_frame_err
);

  import igr_shim_pkg::*;

  fill_t      fill_q;
  pkt_state_t state_q;

  // fill plus beat size, at most 7 + 8 so four bits are enough
  logic [3:0] total;
  logic [3:0] last_idx;

  assign total    = {1'b0, fill_q} + i_rx_nwords;
  assign last_idx = total - 4'd1;

  // a segment closes when slot 7 fills or the packet ends
  assign o_seg_close = i_rx_v && (i_rx_eop || (total >= 4'd8));
  assign o_close_eop = i_rx_v && i_rx_eop;

  // eop beats never cross the boundary, so the last index fits in a slot
  assign o_close_pos = last_idx[2:0];

  assign o_sop_cap = i_rx_v && i_rx_sop;

  // sop only expected between packets, body beats only inside one
  assign o_frame_err = i_rx_v &&
                       (i_rx_sop ? (state_q == PKT_BODY) : (state_q == PKT_IDLE));

  //--------------------------------------------------------------------------
  // slot steering
  //--------------------------------------------------------------------------

  // slot s is fed by lane (s - fill) mod 8
  // slots at or above fill belong to the open segment, and the ones below
  // fill only take a word when the beat runs past slot 7 and wraps
  always_comb begin
    fill_t lane;
    logic  hit;
    for (int s = 0; s < SEG_WORDS; s++) begin
      lane = fill_t'(s) - fill_q;
      hit  = ({1'b0, lane} < i_rx_nwords);
      o_slot_sel[s] = hit ? {1'b0, lane} : LANE_PAD;
      o_slot_we[s]  = i_rx_v && hit && (fill_t'(s) >= fill_q);
      o_wrap_we[s]  = i_rx_v && !i_rx_eop && hit && (fill_t'(s) < fill_q);
    end
  end

  //--------------------------------------------------------------------------
  // fill counter and packet state
  //--------------------------------------------------------------------------

  // fill wraps modulo 8 naturally, and eop always restarts at slot 0
  // any beat that is not eop leaves the machine inside a packet, which also
  // lets a stray body beat resync after a framing error
  always_ff @(posedge cclk) begin
    if (rst) begin
      fill_q  <= '0;
      state_q <= PKT_IDLE;
    end else if (i_rx_v) begin
      if (i_rx_eop) begin
        fill_q  <= '0;
        state_q <= PKT_IDLE;
      end else begin
        fill_q  <= total[2:0];
        state_q <= PKT_BODY;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/igr_shim_pkg.sv ====
//--------------------------------------------------------------------------
// shared widths, types and constants for the ingress shim that packs
// ethernet receive beats into aligned 64-byte packet buffer segments
// every shim module imports this package; the layout is fixed to eight
// 72-bit words per segment
//--------------------------------------------------------------------------
`default_nettype none

package igr_shim_pkg;

  // a segment is eight words, which is 64 data bytes
  localparam int SEG_WORDS = 8;

  // receive word, ecc byte sits above the 64 data bits
  typedef logic [71:0] word_w_ecc_t;

  // slot source, 0..7 pick an input lane and 8 picks the pad word
  typedef logic [3:0]  lane_sel_t;
  typedef logic [7:0]  slot_mask_t;

  // filled slots in the open segment, also used as a slot index
  typedef logic [2:0]  fill_t;

  // valid words in a beat, 1 to 8
  typedef logic [3:0]  nwords_t;

  typedef logic [2:0]  tc_t;

  // bit 0 is the port receive error, bit 1 a framing error seen here
  typedef logic [1:0]  err_t;
  typedef logic [31:0] ts_t;

  typedef enum logic {
    PKT_IDLE = 1'b0,
    PKT_BODY = 1'b1
  } pkt_state_t;

  // select code that steers the pad word into a slot
  localparam lane_sel_t LANE_PAD = 4'd8;

  // pad words carry a fixed ecc byte over zero data
  localparam word_w_ecc_t PAD_WORD = {8'h06, 64'h0};

endpackage

`default_nettype wire

// ==== source/igr_shim_result.sv ====
//--------------------------------------------------------------------------
// result stage of the ingress shim
// registers each finished segment with its metadata on the closing beat
// and raises a one-cycle valid toward the packet buffer
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module igr_shim_result (
  input  logic                  cclk,
  input  logic                  rst,
  input  igr_shim_pkg::word_w_ecc_t [igr_shim_pkg::SEG_WORDS-1:0] i_live_seg,
  input  logic                  i_seg_close,
  input  logic                  i_close_eop,
  input  igr_shim_pkg::fill_t   i_close_pos,
  input  logic                  i_frame_err,
  input  logic                  i_sop_flag,
  input  igr_shim_pkg::tc_t     i_sop_tc,
  input  igr_shim_pkg::ts_t     i_sop_ts,
  input  igr_shim_pkg::err_t    i_sop_err,
  input  igr_shim_pkg::err_t    i_rx_err,
  output logic                  o_seg_v,
  output igr_shim_pkg::word_w_ecc_t [igr_shim_pkg::SEG_WORDS-1:0] o_seg_data,
  output logic                  o_seg_sop,
  output logic                  o_seg_eop,
  output igr_shim_pkg::fill_t   o_seg_eop_pos,
  output igr_shim_pkg::tc_t     o_seg_tc,
  output igr_shim_pkg::err_t    o_seg_err,
  output igr_shim_pkg::ts_t     o_seg_ts
);

  import igr_shim_pkg::*;

  // only bit 0 of the port error is meaningful, bit 1 is ours
  err_t close_err;

  assign close_err = i_sop_err | {i_frame_err, i_rx_err[0]};

  // the buffer expects padded data and zero metadata out of reset
  always_ff @(posedge cclk) begin
    if (rst) begin
      o_seg_v       <= 1'b0;
      o_seg_data    <= {SEG_WORDS{PAD_WORD}};
      o_seg_sop     <= 1'b0;
      o_seg_eop     <= 1'b0;
      o_seg_eop_pos <= '0;
      o_seg_tc      <= '0;
      o_seg_err     <= '0;
      o_seg_ts      <= '0;
    end else begin
      o_seg_v <= i_seg_close;
      if (i_seg_close) begin
        o_seg_data    <= i_live_seg;
        o_seg_sop     <= i_sop_flag;
        o_seg_eop     <= i_close_eop;
        // a segment closed by filling always ends at slot 7
        o_seg_eop_pos <= i_close_eop ? i_close_pos : 3'd7;
        o_seg_tc      <= i_sop_tc;
        o_seg_err     <= close_err;
        o_seg_ts      <= i_sop_ts;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/igr_shim_seg.sv ====
//--------------------------------------------------------------------------
// segment assembler of the ingress shim
// holds the partial segment in an eight-word bank fed by per-slot lane
// multiplexers, and keeps the start-of-packet fields for later segments
// the live segment is the bank merged with this beat, ready for the
// result stage on the closing beat
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module igr_shim_seg (
  input  logic                  cclk,
  input  logic                  rst,
  input  igr_shim_pkg::word_w_ecc_t [igr_shim_pkg::SEG_WORDS-1:0] i_rx_data,
  input  igr_shim_pkg::tc_t     i_rx_tc,
  input  igr_shim_pkg::err_t    i_rx_err,
  input  igr_shim_pkg::ts_t     i_rx_ts,
  input  igr_shim_pkg::lane_sel_t [igr_shim_pkg::SEG_WORDS-1:0] i_slot_sel,
  input  igr_shim_pkg::slot_mask_t i_slot_we,
  input  igr_shim_pkg::slot_mask_t i_wrap_we,
  input  logic                  i_sop_cap,
  input  logic                  i_seg_close,
  input  logic                  i_close_eop,
  output igr_shim_pkg::word_w_ecc_t [igr_shim_pkg::SEG_WORDS-1:0] o_live_seg,
  output logic                  o_sop_flag,
  output igr_shim_pkg::tc_t     o_sop_tc,
  output igr_shim_pkg::ts_t     o_sop_ts,
  output igr_shim_pkg::err_t    o_sop_err
);

  import igr_shim_pkg::*;

  word_w_ecc_t [SEG_WORDS-1:0] lane_mux;
  word_w_ecc_t [SEG_WORDS-1:0] bank_q;

  logic  sop_flag_q;
  tc_t   sop_tc_q;
  ts_t   sop_ts_q;
  err_t  sop_err_q;
  logic  beat_v;

  //--------------------------------------------------------------------------
  // per-slot datapath
  //--------------------------------------------------------------------------

  for (genvar s = 0; s < SEG_WORDS; s++) begin : gen_slot

    // select codes 0..7 pick a lane, anything above steers in the pad word
    assign lane_mux[s] = (i_slot_sel[s] < LANE_PAD) ? i_rx_data[i_slot_sel[s][2:0]]
                                                    : PAD_WORD;

    // slots above the fill point still hold pad, so an early eop comes
    // out padded without any extra masking
    assign o_live_seg[s] = i_slot_we[s] ? lane_mux[s] : bank_q[s];

    // the bank must start out padded since the padding above relies on it
    // on close it takes the wrapped words and pads every other slot
    always_ff @(posedge cclk) begin
      if (rst) begin
        bank_q[s] <= PAD_WORD;
      end else if (i_seg_close) begin
        bank_q[s] <= i_wrap_we[s] ? lane_mux[s] : PAD_WORD;
      end else if (i_slot_we[s]) begin
        bank_q[s] <= lane_mux[s];
      end
    end

  end

  //--------------------------------------------------------------------------
  // start-of-packet fields
  //--------------------------------------------------------------------------

  // every valid beat lands at least one word in the open segment
  assign beat_v = |i_slot_we;

  // tc and ts are kept for every segment of the packet, the sop flag only
  // until the first segment closes
  // the error gathers over the beats of one segment, and a beat that wraps
  // seeds the next segment with its own error bits
  always_ff @(posedge cclk) begin
    if (rst || (i_seg_close && i_close_eop)) begin
      sop_flag_q <= 1'b0;
      sop_tc_q   <= '0;
      sop_ts_q   <= '0;
      sop_err_q  <= '0;
    end else begin
      if (i_sop_cap) begin
        sop_tc_q <= i_rx_tc;
        sop_ts_q <= i_rx_ts;
      end
      sop_flag_q <= i_seg_close ? 1'b0 : (i_sop_cap || sop_flag_q);
      if (i_seg_close) begin
        sop_err_q <= (|i_wrap_we) ? i_rx_err : '0;
      end else if (beat_v) begin
        sop_err_q <= sop_err_q | i_rx_err;
      end
    end
  end

  // a sop beat may close its own segment, so its fields bypass the holding
  // registers; the closing beat's error is added by the result stage
  assign o_sop_flag = i_sop_cap || sop_flag_q;
  assign o_sop_tc   = i_sop_cap ? i_rx_tc : sop_tc_q;
  assign o_sop_ts   = i_sop_cap ? i_rx_ts : sop_ts_q;
  assign o_sop_err  = sop_err_q;

endmodule

`default_nettype wire

// ==== source/igr_shim_top.sv ====
//--------------------------------------------------------------------------
// top level of the ingress shim
// connects decode, segment assembler and result stage; a beat that closes
// a segment shows up on the segment outputs one cycle later
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module igr_shim_top (
  input  logic                  cclk,
  input  logic                  rst,
  input  logic                  i_rx_v,
  input  igr_shim_pkg::word_w_ecc_t [igr_shim_pkg::SEG_WORDS-1:0] i_rx_data,
  input  igr_shim_pkg::nwords_t i_rx_nwords,
  input  logic                  i_rx_sop,
  input  logic                  i_rx_eop,
  input  igr_shim_pkg::tc_t     i_rx_tc,
  input  igr_shim_pkg::err_t    i_rx_err,
  input  igr_shim_pkg::ts_t     i_rx_ts,
  output logic                  o_seg_v,
  output igr_shim_pkg::word_w_ecc_t [igr_shim_pkg::SEG_WORDS-1:0] o_seg_data,
  output logic                  o_seg_sop,
  output logic                  o_seg_eop,
  output igr_shim_pkg::fill_t   o_seg_eop_pos,
  output igr_shim_pkg::tc_t     o_seg_tc,
  output igr_shim_pkg::err_t    o_seg_err,
  output igr_shim_pkg::ts_t     o_seg_ts
);

  import igr_shim_pkg::*;

  lane_sel_t [SEG_WORDS-1:0]   slot_sel;
  slot_mask_t                  slot_we;
  slot_mask_t                  wrap_we;
  logic                        sop_cap;
  logic                        seg_close;
  logic                        close_eop;
  fill_t                       close_pos;
  logic                        frame_err;
  word_w_ecc_t [SEG_WORDS-1:0] live_seg;
  logic                        sop_flag;
  tc_t                         sop_tc;
  ts_t                         sop_ts;
  err_t                        sop_err;

  // framing errors on beats that do not close still have to reach their
  // segment, so the assembler gathers them next to the port error
  err_t beat_err;

  assign beat_err = {frame_err, i_rx_err[0]};

  igr_shim_decode u_decode (
    .cclk        (cclk),
    .rst         (rst),
    .i_rx_v      (i_rx_v),
    .i_rx_nwords (i_rx_nwords),
    .i_rx_sop    (i_rx_sop),
    .i_rx_eop    (i_rx_eop),
    .o_slot_sel  (slot_sel),
    .o_slot_we   (slot_we),
    .o_wrap_we   (wrap_we),
    .o_sop_cap   (sop_cap),
    .o_seg_close (seg_close),
    .o_close_eop (close_eop),
    .o_close_pos (close_pos),
    .o_frame_err (frame_err)
  );

  igr_shim_seg u_seg (
    .cclk        (cclk),
    .rst         (rst),
    .i_rx_data   (i_rx_data),
    .i_rx_tc     (i_rx_tc),
    .i_rx_err    (beat_err),
    .i_rx_ts     (i_rx_ts),
    .i_slot_sel  (slot_sel),
    .i_slot_we   (slot_we),
    .i_wrap_we   (wrap_we),
    .i_sop_cap   (sop_cap),
    .i_seg_close (seg_close),
    .i_close_eop (close_eop),
    .o_live_seg  (live_seg),
    .o_sop_flag  (sop_flag),
    .o_sop_tc    (sop_tc),
    .o_sop_ts    (sop_ts),
    .o_sop_err   (sop_err)
  );

  igr_shim_result u_result (
    .cclk          (cclk),
    .rst           (rst),
    .i_live_seg    (live_seg),
    .i_seg_close   (seg_close),
    .i_close_eop   (close_eop),
    .i_close_pos   (close_pos),
    .i_frame_err   (frame_err),
    .i_sop_flag    (sop_flag),
    .i_sop_tc      (sop_tc),
    .i_sop_ts      (sop_ts),
    .i_sop_err     (sop_err),
    .i_rx_err      (i_rx_err),
    .o_seg_v       (o_seg_v),
    .o_seg_data    (o_seg_data),
    .o_seg_sop     (o_seg_sop),
    .o_seg_eop     (o_seg_eop),
    .o_seg_eop_pos (o_seg_eop_pos),
    .o_seg_tc      (o_seg_tc),
    .o_seg_err     (o_seg_err),
    .o_seg_ts      (o_seg_ts)
  );

endmodule

`default_nettype wire

// ==== test/igr_shim_asserts.sv ====
//----------------------------------------------------------------------------
// bound checks for the ingress shim top level
// keeps its own fill count from the receive beats to judge the input
// rules, and ties every segment strobe to a closing beat
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module igr_shim_asserts (
  input logic                  cclk,
  input logic                  rst,
  input logic                  i_rx_v,
  input igr_shim_pkg::nwords_t i_rx_nwords,
  input logic                  i_rx_eop,
  input logic                  o_seg_v
);

  import igr_shim_pkg::*;

  fill_t      fill_q;
  logic [4:0] total;
  logic       seg_close;

  // five bits so an illegal beat size cannot wrap the sum
  assign total     = 5'(fill_q) + 5'(i_rx_nwords);
  assign seg_close = i_rx_v && (i_rx_eop || (total >= 5'd8));

  always_ff @(posedge cclk) begin
    if (rst) begin
      fill_q <= '0;
    end else if (i_rx_v) begin
      fill_q <= i_rx_eop ? 3'd0 : total[2:0];
    end
  end

  // an eop beat must end inside the open segment
  a_eop_in_segment: assert property (@(posedge cclk) disable iff (rst)
    (i_rx_v && i_rx_eop) |-> (total <= 5'd8))
    else $error("end-of-packet beat crosses a segment boundary");

  a_nwords_range: assert property (@(posedge cclk) disable iff (rst)
    i_rx_v |-> ((i_rx_nwords >= 4'd1) && (i_rx_nwords <= 4'd8)))
    else $error("beat word count outside 1 to 8");

  // each strobe needs a closing beat one edge earlier
  a_strobe_after_close: assert property (@(posedge cclk) disable iff (rst)
    o_seg_v |-> $past(seg_close))
    else $error("segment strobe without a closing beat");

endmodule

bind igr_shim_top igr_shim_asserts u_asserts (
  .cclk        (cclk),
  .rst         (rst),
  .i_rx_v      (i_rx_v),
  .i_rx_nwords (i_rx_nwords),
  .i_rx_eop    (i_rx_eop),
  .o_seg_v     (o_seg_v)
);

`default_nettype wire

// ==== test/igr_shim_tb.sv ====
//----------------------------------------------------------------------------
// testbench for the ingress shim
// builds lfsr-driven packets up front, drives them beat by beat and packs
// every word into expected segments with a reference model
// a compare process checks each segment strobe, its cycle, data and metadata
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module igr_shim_tb;

  import igr_shim_pkg::*;

  // one receive beat as generated plus the idle cycles to insert ahead of it
  typedef struct packed {
    word_w_ecc_t [SEG_WORDS-1:0] data;
    nwords_t                     n;
    logic                        sop;
    logic                        eop;
    tc_t                         tc;
    err_t                        err;
    ts_t                         ts;
    logic [1:0]                  idle;
  } beat_t;

  // expected segment whose due field is the compare cycle of its strobe
  typedef struct packed {
    word_w_ecc_t [SEG_WORDS-1:0] data;
    logic                        sop;
    logic                        eop;
    fill_t                       pos;
    tc_t                         tc;
    err_t                        err;
    ts_t                         ts;
    logic [31:0]                 due;
  } seg_t;

  logic                        cclk = 1'b0;
  logic                        rst;
  logic                        i_rx_v;
  word_w_ecc_t [SEG_WORDS-1:0] i_rx_data;
  nwords_t                     i_rx_nwords;
  logic                        i_rx_sop;
  logic                        i_rx_eop;
  tc_t                         i_rx_tc;
  err_t                        i_rx_err;
  ts_t                         i_rx_ts;
  logic                        o_seg_v;
  word_w_ecc_t [SEG_WORDS-1:0] o_seg_data;
  logic                        o_seg_sop;
  logic                        o_seg_eop;
  fill_t                       o_seg_eop_pos;
  tc_t                         o_seg_tc;
  err_t                        o_seg_err;
  ts_t                         o_seg_ts;

  beat_t       beat_q[$];
  seg_t        exp_q[$];
  logic [31:0] lfsr_q;
  int          word_id;
  int          n_cycles;
  int          fail_cnt;
  int          cyc = 0;
  int          seen_seg = 0;
  logic        stim_ready = 1'b0;

  // reference model state for the open segment and the current packet
  word_w_ecc_t [SEG_WORDS-1:0] m_words;
  int          m_fill;
  logic        m_in_pkt;
  logic        m_sop;
  err_t        m_err;
  tc_t         m_tc;
  ts_t         m_ts;
  logic [31:0] m_due;

  igr_shim_top u_igr_shim_top (
    .cclk          (cclk),
    .rst           (rst),
    .i_rx_v        (i_rx_v),
    .i_rx_data     (i_rx_data),
    .i_rx_nwords   (i_rx_nwords),
    .i_rx_sop      (i_rx_sop),
    .i_rx_eop      (i_rx_eop),
    .i_rx_tc       (i_rx_tc),
    .i_rx_err      (i_rx_err),
    .i_rx_ts       (i_rx_ts),
    .o_seg_v       (o_seg_v),
    .o_seg_data    (o_seg_data),
    .o_seg_sop     (o_seg_sop),
    .o_seg_eop     (o_seg_eop),
    .o_seg_eop_pos (o_seg_eop_pos),
    .o_seg_tc      (o_seg_tc),
    .o_seg_err     (o_seg_err),
    .o_seg_ts      (o_seg_ts)
  );

  initial begin
    forever #5 cclk = ~cclk;
  end

  //--------------------------------------------------------------------------
  // stimulus generation
  //--------------------------------------------------------------------------

  // galois lfsr whose output bit is the one shifted out at each step
  function automatic logic [31:0] take_bits(input int nbits);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      b      = lfsr_q[0];
      lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
      r      = {r[30:0], b};
    end
    return r;
  endfunction

  // a running word number in the data makes lost or swapped words visible
  function automatic word_w_ecc_t new_word();
    logic [31:0] lo;
    logic [7:0]  ecc;
    word_id = word_id + 1;
    lo      = take_bits(32);
    ecc     = 8'(take_bits(8));
    return {ecc, 32'(word_id), lo};
  endfunction

  // frame_mode 1 drops the sop of the first beat, 2 puts a sop on beat two
  // an eop beat is always shortened so that it never runs past slot 7
  task automatic gen_packet(input int len, input logic full, input int frame_mode);
    int    left;
    int    fill;
    int    n;
    int    idx;
    beat_t b;
    left = len;
    fill = 0;
    idx  = 0;
    while (left > 0) begin
      n = full ? SEG_WORDS : int'(take_bits(3)) + 1;
      if (n >= left) begin
        n = (fill + left <= SEG_WORDS) ? left : SEG_WORDS - fill;
      end
      b = '0;
      for (int i = 0; i < SEG_WORDS; i++) begin
        if (i < n) begin
          b.data[i] = new_word();
        end else begin
          // unused lanes carry junk that must never reach a segment
          b.data[i] = {8'(take_bits(8)), take_bits(32), take_bits(32)};
        end
      end
      b.n      = nwords_t'(n);
      b.sop    = (idx == 0) ? (frame_mode != 1) : (frame_mode == 2 && idx == 1);
      b.eop    = (n == left);
      b.tc     = tc_t'(take_bits(3));
      b.err[0] = (take_bits(3) == 32'd0);
      b.err[1] = (take_bits(1) != 32'd0);
      b.ts     = take_bits(32);
      b.idle   = (take_bits(2) == 32'd0) ? 2'(take_bits(2)) : 2'd0;
      beat_q.push_back(b);
      n_cycles = n_cycles + 1 + int'(b.idle);
      fill     = b.eop ? 0 : (fill + n) % SEG_WORDS;
      left     = left - n;
      idx      = idx + 1;
    end
  endtask

  task automatic gen_stimulus();
    int len;
    int mode;
    // aligned full beats come first, then short, framing and random packets
    gen_packet(16, 1'b1, 0);
    gen_packet(8, 1'b1, 0);
    gen_packet(24, 1'b1, 0);
    gen_packet(3, 1'b0, 0);
    gen_packet(21, 1'b0, 1);
    gen_packet(19, 1'b0, 2);
    for (int p = 0; p < 80; p++) begin
      len  = int'(take_bits(6)) % 40 + 1;
      mode = int'(take_bits(4));
      gen_packet(len, 1'b0, (mode < 3) ? mode : 0);
    end
  endtask

  //--------------------------------------------------------------------------
  // reference model of segment packing
  //--------------------------------------------------------------------------

  function automatic void push_segment(input logic eop, input fill_t pos);
    seg_t s;
    s.data = m_words;
    s.sop  = m_sop;
    s.eop  = eop;
    s.pos  = pos;
    s.tc   = m_tc;
    s.err  = m_err;
    s.ts   = m_ts;
    s.due  = m_due;
    exp_q.push_back(s);
    m_words = {SEG_WORDS{PAD_WORD}};
    m_fill  = 0;
    m_sop   = 1'b0;
    m_err   = '0;
  endfunction

  // words fill slots in order, a full segment closes and the rest wraps
  // the error of a beat goes to every segment that gets one of its words
  function automatic void pack_beat(input beat_t b);
    logic ferr;
    err_t berr;
    int   n;
    n    = int'(b.n);
    ferr = b.sop ? m_in_pkt : !m_in_pkt;
    berr = {ferr, b.err[0]};
    if (b.sop) begin
      m_sop = 1'b1;
      m_tc  = b.tc;
      m_ts  = b.ts;
    end
    m_err = m_err | berr;
    for (int i = 0; i < n; i++) begin
      m_words[fill_t'(m_fill)] = b.data[i];
      m_fill = m_fill + 1;
      if (m_fill == SEG_WORDS) begin
        push_segment(b.eop && (i == n - 1), 3'd7);
        if (i < n - 1) begin
          m_err = berr;
        end
      end
    end
    if (b.eop && m_fill != 0) begin
      push_segment(1'b1, fill_t'(m_fill - 1));
    end
    // held start-of-packet fields are gone once the packet ends
    if (b.eop) begin
      m_in_pkt = 1'b0;
      m_tc     = '0;
      m_ts     = '0;
      m_sop    = 1'b0;
      m_err    = '0;
    end else begin
      m_in_pkt = 1'b1;
    end
  endfunction

  //--------------------------------------------------------------------------
  // checking
  //--------------------------------------------------------------------------

  task automatic abort_run();
    fail_cnt = fail_cnt + 1;
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_val(input string what, input logic [71:0] got, input logic [71:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // outputs are sampled on the falling edge, half a cycle after they change
  initial begin
    seg_t e;
    forever begin
      @(negedge cclk);
      cyc = cyc + 1;
      if (o_seg_v === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("segment strobe at %0t ns with no segment expected", $time);
          abort_run();
        end else begin
          e        = exp_q.pop_front();
          seen_seg = 1;
          check_val("strobe cycle", 72'(cyc), 72'(e.due));
          for (int w = 0; w < SEG_WORDS; w++) begin
            check_val($sformatf("segment word %0d", w), o_seg_data[w], e.data[w]);
          end
          check_val("sop", 72'(o_seg_sop), 72'(e.sop));
          check_val("eop", 72'(o_seg_eop), 72'(e.eop));
          check_val("eop position", 72'(o_seg_eop_pos), 72'(e.pos));
          check_val("traffic class", 72'(o_seg_tc), 72'(e.tc));
          check_val("error", 72'(o_seg_err), 72'(e.err));
          check_val("timestamp", 72'(o_seg_ts), 72'(e.ts));
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= 32'(cyc)) begin
        $display("expected segment did not appear at %0t ns", $time);
        abort_run();
      end else begin
        check_val("segment strobe", 72'(o_seg_v), 72'(1'b0));
        // until the first segment the output register keeps its reset value
        if (seen_seg == 0 && cyc >= 2) begin
          for (int w = 0; w < SEG_WORDS; w++) begin
            check_val($sformatf("idle word %0d", w), o_seg_data[w], PAD_WORD);
          end
          check_val("idle metadata",
                    72'({o_seg_sop, o_seg_eop, o_seg_eop_pos, o_seg_tc, o_seg_err, o_seg_ts}),
                    72'(0));
        end
      end
    end
  end

  // the limit follows from the generated beats and idle cycles
  initial begin
    wait (stim_ready === 1'b1);
    repeat (n_cycles + 200) @(posedge cclk);
    $display("timeout, the run did not finish within %0d cycles", n_cycles + 200);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  //--------------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------------

  task automatic drive_beat(input beat_t b);
    repeat (b.idle) begin
      @(posedge cclk);
      i_rx_v <= 1'b0;
    end
    @(posedge cclk);
    i_rx_v      <= 1'b1;
    i_rx_data   <= b.data;
    i_rx_nwords <= b.n;
    i_rx_sop    <= b.sop;
    i_rx_eop    <= b.eop;
    i_rx_tc     <= b.tc;
    i_rx_err    <= b.err;
    i_rx_ts     <= b.ts;
    // the beat is taken at the next edge and its strobe shows one falling edge later
    m_due = 32'(cyc + 2);
    pack_beat(b);
  endtask

  initial begin
    beat_t b;
    rst         = 1'b1;
    i_rx_v      = 1'b0;
    i_rx_data   = {SEG_WORDS{PAD_WORD}};
    i_rx_nwords = 4'd1;
    i_rx_sop    = 1'b0;
    i_rx_eop    = 1'b0;
    i_rx_tc     = '0;
    i_rx_err    = '0;
    i_rx_ts     = '0;
    lfsr_q      = 32'h2fac6064;
    word_id     = 0;
    n_cycles    = 20;
    fail_cnt    = 0;
    m_words     = {SEG_WORDS{PAD_WORD}};
    m_fill      = 0;
    m_in_pkt    = 1'b0;
    m_sop       = 1'b0;
    m_err       = '0;
    m_tc        = '0;
    m_ts        = '0;
    gen_stimulus();
    stim_ready = 1'b1;
    repeat (10) @(posedge cclk);
    rst <= 1'b0;
    repeat (5) @(posedge cclk);
    while (beat_q.size() != 0) begin
      b = beat_q.pop_front();
      drive_beat(b);
    end
    @(posedge cclk);
    i_rx_v <= 1'b0;
    while (exp_q.size() != 0) @(posedge cclk);
    repeat (3) @(posedge cclk);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("TB FAILED");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire
